//--- src/smg_pkg.sv
`default_nettype none

package smg_pkg;

    ////////////////////
    // Display geometry
    ////////////////////

    // Six display slots, slot 0 is leftmost
    localparam int NUM_DIGITS = 6;

    // Binary input value
    typedef logic [19:0] bin_t;

    // Six BCD nibbles, slot 0 in the top nibble
    typedef logic [4*NUM_DIGITS-1:0] bcd_t;

    // One digit code
    typedef logic [3:0] nibble_t;

    // Slot index, 6 and 7 mean no decimal point
    typedef logic [2:0] slot_t;

    // Active-low segments a..g in bits 0..6, dp in bit 7
    typedef logic [7:0] seg_t;

    // Active-low digit selects, bit k drives slot k
    typedef logic [NUM_DIGITS-1:0] dig_t;

    // Blank flag per slot
    typedef logic [NUM_DIGITS-1:0] mask_t;

    ////////////////////
    // Code constants
    ////////////////////

    // Non-decimal nibble shown as a single dash
    localparam nibble_t DASH_CODE = 4'hA;

    // Largest value that fits on six digits
    localparam bin_t MAX_VALUE = 20'd999_999;

    // Converter FSM
    typedef enum logic [1:0] {
        CNV_IDLE,
        CNV_SHIFT,
        CNV_DONE
    } cnv_state_t;

endpackage

`default_nettype wire

//--- src/bin_to_bcd.sv
`default_nettype none
`timescale 1ns/10ps

module bin_to_bcd (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 value_valid,
    input  wire smg_pkg::bin_t  value,
    input  wire smg_pkg::slot_t dp_slot,
    output logic                value_ready,
    output smg_pkg::bcd_t       bcd,
    output smg_pkg::slot_t      held_dp_slot,
    output logic                update
);

    localparam int BIN_W = $bits(smg_pkg::bin_t);
    localparam int BCD_W = $bits(smg_pkg::bcd_t);

    smg_pkg::cnv_state_t state;
    logic [4:0]          shift_cnt;

    // Double-dabble working registers
    smg_pkg::bin_t       work_bin;
    smg_pkg::bcd_t       work_bcd;
    smg_pkg::bcd_t       adj_bcd;
    logic                overflow;
    smg_pkg::slot_t      pend_dp;

    assign value_ready = (state == smg_pkg::CNV_IDLE);
    assign update      = (state == smg_pkg::CNV_DONE);

    // Add 3 to every nibble of 5 or more before the shift
    always_comb begin
        for (int i = 0; i < smg_pkg::NUM_DIGITS; i++) begin
            if (work_bcd[4*i +: 4] >= 4'd5)
                adj_bcd[4*i +: 4] = work_bcd[4*i +: 4] + 4'd3;
            else
                adj_bcd[4*i +: 4] = work_bcd[4*i +: 4];
        end
    end

    ////////////////////
    // Control FSM
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= smg_pkg::CNV_IDLE;
            shift_cnt    <= '0;
            bcd          <= '0;
            held_dp_slot <= 3'd7;
        end else begin
            case (state)
                smg_pkg::CNV_IDLE: begin
                    if (value_valid) begin
                        state     <= smg_pkg::CNV_SHIFT;
                        shift_cnt <= '0;
                    end
                end
                smg_pkg::CNV_SHIFT: begin
                    shift_cnt <= shift_cnt + 5'd1;
                    // Last shift lands straight in the output register
                    if (shift_cnt == 5'(BIN_W - 1)) begin
                        state <= smg_pkg::CNV_DONE;
                        if (overflow) begin
                            bcd          <= {smg_pkg::NUM_DIGITS{smg_pkg::DASH_CODE}};
                            held_dp_slot <= 3'd7;
                        end else begin
                            bcd          <= {adj_bcd[BCD_W-2:0], work_bin[BIN_W-1]};
                            held_dp_slot <= pend_dp;
                        end
                    end
                end
                default: begin
                    state <= smg_pkg::CNV_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Datapath
    ////////////////////

    always_ff @(posedge clk) begin
        if (value_valid && value_ready) begin
            work_bin <= value;
            work_bcd <= '0;
            overflow <= (value > smg_pkg::MAX_VALUE);
            pend_dp  <= dp_slot;
        end else if (state == smg_pkg::CNV_SHIFT) begin
            {work_bcd, work_bin} <= {adj_bcd, work_bin} << 1;
        end
    end

endmodule

`default_nettype wire

//--- src/smg_control_module.sv
`default_nettype none
`timescale 1ns/10ps

module smg_control_module #(
    parameter int SLOT_CYCLES = 50_000
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire smg_pkg::bcd_t bcd,
    output smg_pkg::nibble_t   digit,
    output smg_pkg::slot_t     slot
);

    localparam int CNT_W = (SLOT_CYCLES > 1) ? $clog2(SLOT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(SLOT_CYCLES - 1);
    localparam smg_pkg::slot_t LAST_SLOT = 3'(smg_pkg::NUM_DIGITS - 1);

    logic [CNT_W-1:0] count;
    logic             slot_end;
    smg_pkg::slot_t   slot_next;

    ////////////////////
    // Slot timer
    ////////////////////

    assign slot_end = (count == LAST_CNT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            count <= '0;
        else if (slot_end)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    ////////////////////
    // Digit scan
    ////////////////////

    // Six-step sequence, wraps from the last slot to slot 0
    always_comb begin
        if (!slot_end)
            slot_next = slot;
        else if (slot == LAST_SLOT)
            slot_next = '0;
        else
            slot_next = slot + 3'd1;
    end

    // digit follows slot_next so both registers name the same slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot  <= '0;
            digit <= '0;
        end else begin
            slot  <= slot_next;
            digit <= bcd[4*(smg_pkg::NUM_DIGITS - 1 - int'(slot_next)) +: 4];
        end
    end

endmodule

`default_nettype wire

//--- src/zero_blank.sv
`default_nettype none
`timescale 1ns/10ps

module zero_blank (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire smg_pkg::bcd_t  bcd,
    input  wire smg_pkg::slot_t held_dp_slot,
    input  wire                 update,
    output smg_pkg::mask_t      blank_mask
);

    smg_pkg::mask_t mask_next;
    logic           lead_zero;

    ////////////////////
    // Blank rule
    ////////////////////

    // Walk from the leftmost slot while every digit so far is zero.
    // The last slot and the slot carrying the decimal point stay lit,
    // as does anything to their right.
    always_comb begin
        lead_zero = 1'b1;
        for (int k = 0; k < smg_pkg::NUM_DIGITS; k++) begin
            lead_zero    = lead_zero && (bcd[4*(smg_pkg::NUM_DIGITS - 1 - k) +: 4] == 4'd0);
            mask_next[k] = lead_zero
                           && (k < smg_pkg::NUM_DIGITS - 1)
                           && (k < int'(held_dp_slot));
        end
    end

    ////////////////////
    // Mask register
    ////////////////////

    // Only reloaded when the converter presents a fresh result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            blank_mask <= '0;
        else if (update)
            blank_mask <= mask_next;
    end

endmodule

`default_nettype wire

//--- src/seg_encode.sv
`default_nettype none
`timescale 1ns/10ps

module seg_encode (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire smg_pkg::nibble_t digit,
    input  wire smg_pkg::slot_t   slot,
    input  wire smg_pkg::slot_t   held_dp_slot,
    input  wire smg_pkg::mask_t   blank_mask,
    output smg_pkg::seg_t         seg,
    output smg_pkg::dig_t         dig
);

    logic [6:0]    seg7;
    smg_pkg::seg_t seg_next;
    smg_pkg::dig_t dig_next;

    ////////////////////
    // Segment decode
    ////////////////////

    // Active low, g..a from bit 6 down to bit 0
    always_comb begin
        case (digit)
            4'd0:               seg7 = 7'b100_0000;
            4'd1:               seg7 = 7'b111_1001;
            4'd2:               seg7 = 7'b010_0100;
            4'd3:               seg7 = 7'b011_0000;
            4'd4:               seg7 = 7'b001_1001;
            4'd5:               seg7 = 7'b001_0010;
            4'd6:               seg7 = 7'b000_0010;
            4'd7:               seg7 = 7'b111_1000;
            4'd8:               seg7 = 7'b000_0000;
            4'd9:               seg7 = 7'b001_0000;
            smg_pkg::DASH_CODE: seg7 = 7'b011_1111;
            default:            seg7 = 7'b111_1111;
        endcase
    end

    // Blanked slot turns everything off, dp included
    always_comb begin
        if (blank_mask[slot])
            seg_next = 8'hFF;
        else
            seg_next = {(slot != held_dp_slot), seg7};
    end

    // One low bit for the scanned slot
    assign dig_next = ~(smg_pkg::dig_t'(1) << slot);

    ////////////////////
    // Output registers
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg <= 8'hFF;
            dig <= '1;
        end else begin
            seg <= seg_next;
            dig <= dig_next;
        end
    end

endmodule

`default_nettype wire

//--- src/smg_display_top.sv
`default_nettype none
`timescale 1ns/10ps

module smg_display_top #(
    parameter int SLOT_CYCLES = 50_000
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 value_valid,
    input  wire smg_pkg::bin_t  value,
    input  wire smg_pkg::slot_t dp_slot,
    output logic                value_ready,
    output smg_pkg::seg_t       seg,
    output smg_pkg::dig_t       dig
);

    // Held result from the converter
    smg_pkg::bcd_t    bcd;
    smg_pkg::slot_t   held_dp_slot;
    logic             update;

    // Scan and blank results
    smg_pkg::nibble_t digit;
    smg_pkg::slot_t   slot;
    smg_pkg::mask_t   blank_mask;

    bin_to_bcd bin_to_bcd_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .value_valid  (value_valid),
        .value        (value),
        .dp_slot      (dp_slot),
        .value_ready  (value_ready),
        .bcd          (bcd),
        .held_dp_slot (held_dp_slot),
        .update       (update)
    );

    smg_control_module #(
        .SLOT_CYCLES (SLOT_CYCLES)
    ) smg_control_module_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bcd   (bcd),
        .digit (digit),
        .slot  (slot)
    );

    zero_blank zero_blank_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .bcd          (bcd),
        .held_dp_slot (held_dp_slot),
        .update       (update),
        .blank_mask   (blank_mask)
    );

    seg_encode seg_encode_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .digit        (digit),
        .slot         (slot),
        .held_dp_slot (held_dp_slot),
        .blank_mask   (blank_mask),
        .seg          (seg),
        .dig          (dig)
    );

endmodule

`default_nettype wire

//--- bench/smg_display_model.svh
`ifndef SMG_DISPLAY_MODEL_SVH
`define SMG_DISPLAY_MODEL_SVH

////////////////////
// Display model
////////////////////

// Largest number that fits, anything above shows dashes
localparam int SHOW_MAX  = 999_999;
localparam int DASH_DIG  = 10;

// Expected display contents, slot 0 leftmost
int             model_digit [smg_pkg::NUM_DIGITS];
smg_pkg::mask_t model_mask;
int             model_dp;

// Lit segments, active high, g in bit 6 down to a in bit 0
function automatic logic [6:0] segments_on(input int code);
    case (code)
        0:        return 7'h3F;
        1:        return 7'h06;
        2:        return 7'h5B;
        3:        return 7'h4F;
        4:        return 7'h66;
        5:        return 7'h6D;
        6:        return 7'h7D;
        7:        return 7'h07;
        8:        return 7'h7F;
        9:        return 7'h6F;
        DASH_DIG: return 7'h40;
        default:  return 7'h00;
    endcase
endfunction

// Power-up contents, six zeros and nothing blanked
function automatic void model_reset();
    for (int k = 0; k < smg_pkg::NUM_DIGITS; k++) begin
        model_digit[k] = 0;
    end
    model_mask = '0;
    model_dp   = 7;
endfunction

function automatic void model_accept(input int number, input int dp);
    int   rest;
    logic leading;
    rest = number;
    for (int k = smg_pkg::NUM_DIGITS - 1; k >= 0; k--) begin
        model_digit[k] = (number > SHOW_MAX) ? DASH_DIG : rest % 10;
        rest = rest / 10;
    end
    model_dp = (number > SHOW_MAX) ? 7 : dp;
    // Leading zeros go dark, never the last digit or the dp digit
    leading = 1'b1;
    for (int k = 0; k < smg_pkg::NUM_DIGITS; k++) begin
        leading       = leading && (model_digit[k] == 0);
        model_mask[k] = leading && (k < smg_pkg::NUM_DIGITS - 1) && (k < model_dp);
    end
endfunction

// Active-low segment byte expected on one slot
function automatic smg_pkg::seg_t model_seg(input int slot);
    if (model_mask[slot])
        return 8'hFF;
    return ~{(slot == model_dp), segments_on(model_digit[slot])};
endfunction

`endif

//--- bench/smg_display_tb.sv
`default_nettype none
`timescale 1ns/10ps

module smg_display_tb;

    localparam int SLOT_CYC   = 8;
    localparam int FRAME_CYC  = SLOT_CYC * smg_pkg::NUM_DIGITS;
    localparam int WAIT_LIMIT = 200;

    logic           clk;
    logic           rst_n;
    logic           value_valid;
    smg_pkg::bin_t  value;
    smg_pkg::slot_t dp_slot;
    logic           value_ready;
    smg_pkg::seg_t  seg;
    smg_pkg::dig_t  dig;

    int             error_count;
    int             tests_run;
    int             seg_checks;
    int             transfers;
    int             low_periods;
    int             low_len;
    int             ready_cnt;
    logic           settled;
    smg_pkg::mask_t slots_seen;
    logic [22:0]    accepted_q[$];
    logic [22:0]    offered_q[$];

    `include "smg_display_model.svh"

    smg_display_top #(
        .SLOT_CYCLES (SLOT_CYC)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .value_valid (value_valid),
        .value       (value),
        .dp_slot     (dp_slot),
        .value_ready (value_ready),
        .seg         (seg),
        .dig         (dig)
    );

    always #2 clk = ~clk;

    ////////////////////
    // Checks and waits
    ////////////////////

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic end_run();
        $display("Summary: %0d tests, %0d segment checks, %0d errors",
                 tests_run, seg_checks, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout after %0d cycles: %s", WAIT_LIMIT, what);
        error_count++;
        end_run();
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (error_count == start)
            $display("Test %-16s ok", name);
        else
            $display("Test %-16s %0d errors", name, error_count - start);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_settled();
        int waited;
        waited = 0;
        while (!settled && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!settled)
            timeout_fail("display did not settle after a conversion");
    endtask

    // Offer one value and hold it until the converter takes it
    task automatic send_value(input int number, input int dp, input logic keep_valid);
        int waited;
        waited      = 0;
        value_valid = 1'b1;
        value       = smg_pkg::bin_t'(number);
        dp_slot     = smg_pkg::slot_t'(dp);
        while (!value_ready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!value_ready) begin
            timeout_fail("value_ready stayed low with a value pending");
        end else begin
            @(posedge clk);
            #1;
            offered_q.push_back({dp_slot, value});
            if (!keep_valid)
                value_valid = 1'b0;
        end
    endtask

    task automatic check_frames(input int n);
        slots_seen = '0;
        wait_cycles(n * FRAME_CYC);
        check_value(slots_seen, 6'h3F, "every slot compared");
    endtask

    task automatic check_scan_order();
        int            waited;
        int            run;
        smg_pkg::dig_t prev;
        smg_pkg::dig_t want;
        waited = 0;
        prev   = dig;
        // Sync to the first cycle of slot 0
        while (!(dig == 6'b111110 && prev != 6'b111110) && waited < WAIT_LIMIT) begin
            prev = dig;
            @(posedge clk);
            #1;
            waited++;
        end
        if (!(dig == 6'b111110 && prev != 6'b111110)) begin
            timeout_fail("dig never switched to slot 0");
        end else begin
            for (int s = 0; s < smg_pkg::NUM_DIGITS; s++) begin
                want = ~(6'b000001 << s);
                check_value(dig, want, $sformatf("dig selects slot %0d", s));
                run = 0;
                while (dig == want && run < WAIT_LIMIT) begin
                    run++;
                    @(posedge clk);
                    #1;
                end
                check_value(run, SLOT_CYC, $sformatf("cycles on slot %0d", s));
            end
            check_value(dig, 6'b111110, "dig wraps to slot 0");
        end
    endtask

    ////////////////////
    // Output monitor
    ////////////////////

    always @(negedge clk) begin : monitor
        int mon_slot;
        if (!rst_n) begin
            settled   = 1'b0;
            ready_cnt = 0;
            low_len   = 0;
        end else begin
            if (settled && $countones(~dig) == 1) begin
                mon_slot = 0;
                for (int k = 0; k < smg_pkg::NUM_DIGITS; k++) begin
                    if (!dig[k])
                        mon_slot = k;
                end
                check_value(seg, model_seg(mon_slot), $sformatf("seg on slot %0d", mon_slot));
                slots_seen[mon_slot] = 1'b1;
                seg_checks++;
            end
            if (!value_ready) begin
                low_len++;
            end else begin
                // End of a busy period
                if (low_len != 0) begin
                    check_value(low_len, 21, "value_ready low period");
                    low_periods++;
                    low_len = 0;
                end
                if (value_valid) begin
                    model_accept(value, dp_slot);
                    accepted_q.push_back({dp_slot, value});
                    transfers++;
                    settled   = 1'b0;
                    ready_cnt = 0;
                end else begin
                    if (ready_cnt < 4)
                        ready_cnt++;
                    settled = (ready_cnt == 4);
                end
            end
        end
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int start;
        int v;
        int d;
        int t0;
        int l0;
        int small_val[3];
        int small_dp[3];
        small_val   = '{0, 5, 1200};
        small_dp    = '{2, 4, 7};
        clk         = 1'b0;
        rst_n       = 1'b0;
        value_valid = 1'b0;
        value       = '0;
        dp_slot     = '0;
        error_count = 0;
        tests_run   = 0;
        seg_checks  = 0;
        transfers   = 0;
        low_periods = 0;
        low_len     = 0;
        ready_cnt   = 0;
        settled     = 1'b0;
        slots_seen  = '0;
        void'($urandom(32'h3aa05cd2));
        model_reset();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Power-up display
        start = error_count;
        check_value(value_ready, 1'b1, "value_ready after reset");
        wait_settled();
        check_frames(1);
        report_test("reset state", start);

        start = error_count;
        for (int i = 0; i < 40; i++) begin
            v = $urandom % 1_000_000;
            d = $urandom % 8;
            send_value(v, d, 1'b0);
            wait_settled();
            check_frames(2);
        end
        report_test("random values", start);

        start = error_count;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                send_value(small_val[i], small_dp[j], 1'b0);
                wait_settled();
                check_frames(1);
            end
        end
        report_test("zero blanking", start);

        start = error_count;
        for (int i = 0; i < 8; i++) begin
            if (i == 0)
                v = 1_000_000;
            else if (i == 1)
                v = 1_048_575;
            else
                v = 1_000_000 + $urandom % 48_576;
            send_value(v, $urandom % 8, 1'b0);
            wait_settled();
            check_frames(1);
        end
        report_test("overflow", start);

        // Back-to-back offers with random idle gaps
        start = error_count;
        offered_q.delete();
        accepted_q.delete();
        t0 = transfers;
        l0 = low_periods;
        for (int i = 0; i < 12; i++) begin
            v = $urandom % 1_048_576;
            d = $urandom % 8;
            send_value(v, d, 1'b1);
            if ($urandom % 3 == 0) begin
                value_valid = 1'b0;
                wait_cycles(1 + $urandom % 25);
            end
        end
        value_valid = 1'b0;
        wait_settled();
        check_frames(1);
        check_value(transfers - t0, 12, "accepted transfers");
        check_value(low_periods - l0, 12, "busy periods");
        check_value(accepted_q.size(), offered_q.size(), "accepted value count");
        for (int i = 0; i < offered_q.size() && i < accepted_q.size(); i++)
            check_value(accepted_q[i], offered_q[i], $sformatf("accepted value %0d", i));
        report_test("handshake", start);

        start = error_count;
        check_scan_order();
        report_test("scan order", start);

        end_run();
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+bench
src/smg_pkg.sv
src/bin_to_bcd.sv
src/smg_control_module.sv
src/zero_blank.sv
src/seg_encode.sv
src/smg_display_top.sv
bench/smg_display_tb.sv
